// File: filelist.f
+incdir+include
logic/game_pkg.sv
logic/note_stream_if.sv
logic/game_fsm.sv
logic/session_regs.sv
logic/song_menu.sv
logic/note_fetcher.sv
logic/note_judge.sv
logic/game_top.sv
verification/song_rom_model.sv
verification/tb_game_top.sv

// File: Bender.yml
package:
  name: game_controller

export_include_dirs:
  - include

sources:
  - logic/game_pkg.sv
  - logic/note_stream_if.sv
  - logic/game_fsm.sv
  - logic/session_regs.sv
  - logic/song_menu.sv
  - logic/note_fetcher.sv
  - logic/note_judge.sv
  - logic/game_top.sv
  - target: test
    files:
      - verification/song_rom_model.sv
      - verification/tb_game_top.sv

// File: verification/tb_game_top.sv
`timescale 1ns/100ps
`include "game_macros.svh"

module tb_game_top;

    localparam int NOTE_PERIOD = 20;
    localparam int NOTE_HOLD = 6;
    localparam int SCORE_INTERVAL = 7;
    localparam int NUM_ROWS = 5;

    typedef struct packed {
        logic [1:0] game_type;
        logic [1:0] song;
        logic custom;
        logic follow;   // play the head note, else note 100
        logic finishes; // song expected to reach finish
    } test_row_t;

    logic clk_in;
    logic rst_in;
    logic game_on;
    logic btnu;
    logic btnd;
    logic btnc;
    game_pkg::note_t keyboard_note;
    logic [1:0] game_type_in;
    logic custom_song_activated;
    logic [`ROM_DATA_W-1:0] rom_data;
    game_pkg::vga_mode_e vga_mode;
    game_pkg::song_choice_t menu_select;
    logic [`WINDOW_NOTES*`NOTE_W-1:0] current_notes;
    logic [`SCORE_W-1:0] current_score;
    logic [`SCORE_W-1:0] current_max_score;
    logic shifting_out;
    logic [`ROM_ADDR_W-1:0] rom_addr;

    test_row_t rows [NUM_ROWS];
    game_pkg::note_t head_note;
    game_pkg::note_t newest_note;
    logic follow = 1'b0;
    logic monitoring = 1'b0;
    int monitor_song = 0;
    int shift_count = 0;
    int play_cycles = 0;
    int test_count = 0;
    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    game_top #(
        .note_period(NOTE_PERIOD),
        .note_hold(NOTE_HOLD),
        .score_interval(SCORE_INTERVAL)
    ) u_dut (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .game_on(game_on),
        .btnu(btnu),
        .btnd(btnd),
        .btnc(btnc),
        .keyboard_note(keyboard_note),
        .game_type_in(game_type_in),
        .custom_song_activated(custom_song_activated),
        .rom_data(rom_data),
        .vga_mode(vga_mode),
        .menu_select(menu_select),
        .current_notes(current_notes),
        .current_score(current_score),
        .current_max_score(current_max_score),
        .shifting_out(shifting_out),
        .rom_addr(rom_addr)
    );

    song_rom_model u_rom (.clk_in(clk_in), .addr(rom_addr), .data(rom_data));

    assign head_note = current_notes[`WINDOW_NOTES*`NOTE_W-1 -: `NOTE_W];
    assign newest_note = current_notes[`NOTE_W-1:0];

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the song never reached its end", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    // player model
    always @(posedge clk_in) begin
        #1;
        keyboard_note = follow ? head_note : 7'd100;
    end

    function automatic int song_len(input int song);
        return 8 + 3 * song;
    endfunction

    // k-th note fetched for a song or a rest past the end marker
    function automatic int expected_note(input int song, input int k);
        if (k < song_len(song)) begin
            return int'(u_rom.mem[song * `SONG_STRIDE + k]);
        end else if (k == song_len(song)) begin
            return `END_NOTE;
        end
        return `REST_NOTE;
    endfunction

    function automatic int timeout_limit();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += song_len(rows[i].song) * (NOTE_PERIOD + NOTE_HOLD + 12);
        end
        return total * 3 / 2 + 200;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // cycles spent in play, for the expected score
    always @(negedge clk_in) begin
        if (vga_mode == game_pkg::VGA_GAME) begin
            play_cycles++;
        end
    end

    always @(negedge clk_in) begin
        if (monitoring && shifting_out) begin
            shift_count++;
            check_value("newest note", expected_note(monitor_song, shift_count - 1), newest_note);
            check_value("rom_addr", monitor_song * `SONG_STRIDE + shift_count, rom_addr);
            if (shift_count >= `WINDOW_NOTES) begin
                check_value("head note",
                            expected_note(monitor_song, shift_count - `WINDOW_NOTES), head_note);
            end else begin
                check_value("head note", 0, head_note); // still preloading
            end
            for (int i = 0; i < `WINDOW_NOTES; i++) begin
                check_value("window note not filler", 1,
                            (current_notes[i*`NOTE_W +: `NOTE_W] < 120) ||
                            (current_notes[i*`NOTE_W +: `NOTE_W] > 123));
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk_in);
        #1;
    endtask

    task automatic press_button(input int which); // 0 up, 1 down
        btnu = (which == 0);
        btnd = (which == 1);
        next_cycle();
        btnu = 1'b0;
        btnd = 1'b0;
        next_cycle();
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: FAILED, %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic load_table();
        // type, song, custom, follow, finishes
        rows[0] = {2'd3, 2'd0, 1'b0, 1'b1, 1'b1};
        rows[1] = {2'd3, 2'd2, 1'b0, 1'b0, 1'b1};
        rows[2] = {2'd2, 2'd1, 1'b0, 1'b0, 1'b0}; // learn, wrong note held
        rows[3] = {2'd2, 2'd3, 1'b1, 1'b1, 1'b1};
        rows[4] = {2'd0, 2'd1, 1'b1, 1'b1, 1'b1}; // type 0 plays
    endtask

    task automatic menu_test();
        int errors_before;
        errors_before = error_count;
        game_on = 1'b1;
        repeat (2) next_cycle();
        check_value("vga_mode", game_pkg::VGA_BASIC_SONG_MENU, vga_mode);
        repeat (4) press_button(0);
        check_value("menu_select", 2, menu_select);
        custom_song_activated = 1'b1;
        next_cycle();
        check_value("vga_mode", game_pkg::VGA_CUSTOM_SONG_MENU, vga_mode);
        repeat (4) press_button(0);
        check_value("menu_select", 3, menu_select);
        custom_song_activated = 1'b0;
        next_cycle();
        check_value("menu_select", 2, menu_select); // clamped to top choice
        repeat (4) press_button(1);
        check_value("menu_select", 0, menu_select);
        report_test("menu cursor", errors_before);
    endtask

    task automatic run_row(input test_row_t row, input int idx);
        int errors_before;
        int expected_max;
        logic learn;
        game_pkg::vga_mode_e active_mode;
        game_pkg::vga_mode_e menu_mode;
        errors_before = error_count;
        play_cycles = 0;
        learn = (row.game_type == game_pkg::TYPE_LEARN);
        active_mode = learn ? game_pkg::VGA_LEARN : game_pkg::VGA_GAME;
        menu_mode = row.custom ? game_pkg::VGA_CUSTOM_SONG_MENU : game_pkg::VGA_BASIC_SONG_MENU;
        game_on = 1'b0;
        game_type_in = row.game_type;
        custom_song_activated = row.custom;
        follow = row.follow;
        repeat (2) next_cycle();
        check_value("vga_mode", game_pkg::VGA_MAIN_MENU, vga_mode);
        game_on = 1'b1;
        repeat (2) next_cycle();
        check_value("vga_mode", menu_mode, vga_mode);
        repeat (3) press_button(1);
        repeat (row.song) press_button(0);
        check_value("menu_select", row.song, menu_select);
        btnc = 1'b1;
        next_cycle();
        btnc = 1'b0;
        check_value("vga_mode", active_mode, vga_mode);
        next_cycle(); // old window may still shift here
        monitor_song = row.song;
        shift_count = 0;
        monitoring = 1'b1;
        while (shift_count < `WINDOW_NOTES) begin
            next_cycle();
        end
        if (!row.finishes) begin
            repeat (100) next_cycle();
            check_value("shifts after preload", `WINDOW_NOTES, shift_count);
            check_value("vga_mode", active_mode, vga_mode);
        end else begin
            while (vga_mode == active_mode) begin
                next_cycle();
            end
            check_value("vga_mode at finish", game_pkg::VGA_MAIN_MENU, vga_mode);
            check_value("head note at finish", `END_NOTE, head_note);
            check_value("shifts at finish", song_len(row.song) + `WINDOW_NOTES, shift_count);
            next_cycle();
            check_value("vga_mode", game_pkg::VGA_MAIN_MENU, vga_mode); // idle
            next_cycle();
            check_value("vga_mode", menu_mode, vga_mode);
        end
        // first play cycle clears the scores, then one step per interval
        expected_max = learn ? 0 : (play_cycles - 1) / SCORE_INTERVAL;
        check_value("current_max_score", expected_max, current_max_score);
        if (!learn) begin
            check_value("current_max_score above zero", 1, current_max_score > 0);
        end
        if (learn || !row.follow) begin
            check_value("current_score", 0, current_score);
        end else begin
            check_value("current_score", expected_max, current_score);
        end
        monitoring = 1'b0;
        game_on = 1'b0;
        next_cycle();
        check_value("vga_mode after game off", game_pkg::VGA_MAIN_MENU, vga_mode);
        report_test($sformatf("row %0d", idx), errors_before);
    endtask

    initial begin
        rst_in = 1'b1;
        game_on = 1'b0;
        btnu = 1'b0;
        btnd = 1'b0;
        btnc = 1'b0;
        keyboard_note = '0;
        game_type_in = game_pkg::TYPE_PLAY;
        custom_song_activated = 1'b0;
        load_table();
        cycle_limit = timeout_limit();
        repeat (8) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        menu_test();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i], i);
        end
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verification/song_rom_model.sv
`timescale 1ns/100ps
`include "game_macros.svh"

module song_rom_model #(
    parameter logic [31:0] seed = 32'hae5a_73e0,
    parameter int num_songs = 4
) (
    input  logic clk_in,
    input  logic [`ROM_ADDR_W-1:0] addr,
    output logic [`ROM_DATA_W-1:0] data
);

    localparam int DEPTH = 1 << `ROM_ADDR_W;

    logic [`ROM_DATA_W-1:0] mem [DEPTH];
    logic [`ROM_DATA_W-1:0] rdata = '0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // filler codes 120..123, folded from every address bit
    function automatic logic [`ROM_DATA_W-1:0] filler(input int a);
        int f;
        f = a ^ (a >> 2) ^ (a >> 4) ^ (a >> 6) ^ (a >> 8);
        return `ROM_DATA_W'(120 + (f & 3));
    endfunction

    initial begin
        logic [31:0] rnd;
        int song;
        int offset;
        rnd = seed;
        for (int a = 0; a < DEPTH; a++) begin
            rnd = xorshift(rnd); // one step per address
            song = a / `SONG_STRIDE;
            offset = a % `SONG_STRIDE;
            if ((song < num_songs) && (offset < 8 + 3 * song)) begin
                mem[a] = `ROM_DATA_W'(rnd % 96);
            end else if ((song < num_songs) && (offset == 8 + 3 * song)) begin
                mem[a] = `ROM_DATA_W'(`END_NOTE); // end marker
            end else begin
                mem[a] = filler(a);
            end
        end
    end

    always @(posedge clk_in) begin
        rdata <= mem[addr]; // one cycle latency
    end

    assign data = rdata;

endmodule

// File: logic/game_top.sv
`timescale 1ns/100ps
`include "game_macros.svh"

module game_top #(
    parameter int note_period = `DEF_NOTE_PERIOD,
    parameter int note_hold = `DEF_NOTE_HOLD,
    parameter int score_interval = `DEF_SCORE_INTERVAL
) (
    input  logic clk_in,
    input  logic rst_in,
    input  logic game_on,
    input  logic btnu,
    input  logic btnd,
    input  logic btnc,
    input  game_pkg::note_t keyboard_note,
    input  logic [1:0] game_type_in,
    input  logic custom_song_activated,
    input  logic [`ROM_DATA_W-1:0] rom_data,
    output game_pkg::vga_mode_e vga_mode,
    output game_pkg::song_choice_t menu_select,
    output logic [`WINDOW_NOTES*`NOTE_W-1:0] current_notes,
    output logic [`SCORE_W-1:0] current_score,
    output logic [`SCORE_W-1:0] current_max_score,
    output logic shifting_out,
    output logic [`ROM_ADDR_W-1:0] rom_addr
);

    game_pkg::game_state_e state;

    note_stream_if ns ();

    game_fsm u_fsm (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .game_on(game_on),
        .btnc(btnc),
        .custom_song_activated(custom_song_activated),
        .ns(ns.ctrl),
        .state(state),
        .vga_mode(vga_mode)
    );

    session_regs u_session (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .game_on(game_on),
        .game_type_in(game_type_in),
        .menu_choice(menu_select),
        .ns(ns.cfg)
    );

    song_menu u_menu (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .btnu(btnu),
        .btnd(btnd),
        .custom_song_activated(custom_song_activated),
        .choice(menu_select)
    );

    note_fetcher #(.note_period(note_period)) u_fetcher (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .ns(ns.fetch),
        .rom_addr(rom_addr),
        .rom_data(rom_data)
    );

    note_judge #(.score_interval(score_interval), .note_hold(note_hold)) u_judge (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .keyboard_note(keyboard_note),
        .state(state),
        .ns(ns.judge),
        .score(current_score),
        .max_score(current_max_score)
    );

    assign current_notes = ns.window.flat; // flat view for the display
    assign shifting_out = ns.shift;

endmodule

// File: logic/note_judge.sv
`timescale 1ns/100ps
`include "game_macros.svh"

module note_judge #(
    parameter int score_interval = `DEF_SCORE_INTERVAL,
    parameter int note_hold = `DEF_NOTE_HOLD
) (
    input  logic clk_in,
    input  logic rst_in,
    input  game_pkg::note_t keyboard_note,
    input  game_pkg::game_state_e state,
    note_stream_if.judge ns,
    output logic [`SCORE_W-1:0] score,
    output logic [`SCORE_W-1:0] max_score
);

    localparam int INTERVAL_W = $clog2(score_interval + 1);
    localparam int HOLD_W = $clog2(note_hold + 1);

    game_pkg::game_state_e prev_state;
    game_pkg::note_t head;
    game_pkg::note_t prev_note;
    logic [INTERVAL_W-1:0] score_cnt;
    logic [HOLD_W-1:0] hold_cnt;
    logic game_entry;
    logic note_held;

    assign head = ns.window.notes[`WINDOW_NOTES-1];
    assign game_entry = (prev_state == game_pkg::ST_SONG_SELECT) &&
                        ((state == game_pkg::ST_PLAY) || (state == game_pkg::ST_LEARN));
    // correct note, unchanged since last cycle
    assign note_held = (state == game_pkg::ST_LEARN) && (keyboard_note == head) &&
                       (keyboard_note == prev_note) && (head != `END_NOTE);

    // play mode scoring
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            prev_state <= game_pkg::ST_IDLE;
            score <= '0;
            max_score <= '0;
            score_cnt <= '0;
        end else begin
            prev_state <= state;
            if (game_entry) begin
                score <= '0; // fresh song
                max_score <= '0;
                score_cnt <= '0;
            end else if (state == game_pkg::ST_PLAY) begin
                if (score_cnt == INTERVAL_W'(score_interval - 1)) begin
                    score_cnt <= '0;
                    max_score <= max_score + 1'b1;
                    score <= score + ((keyboard_note == head) ? 1'b1 : 1'b0);
                end else begin
                    score_cnt <= score_cnt + 1'b1;
                end
            end else begin
                score_cnt <= '0;
            end
        end
    end

    // learn mode hold detection
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            prev_note <= '0;
            hold_cnt <= '0;
            ns.advance <= 1'b0;
        end else begin
            prev_note <= keyboard_note;
            ns.advance <= 1'b0;
            if (note_held) begin
                if (hold_cnt == HOLD_W'(note_hold - 1)) begin
                    ns.advance <= 1'b1;
                    hold_cnt <= '0; // next note needs its own hold
                end else begin
                    hold_cnt <= hold_cnt + 1'b1;
                end
            end else begin
                hold_cnt <= '0;
            end
        end
    end

endmodule

// File: logic/note_fetcher.sv
`timescale 1ns/100ps
`include "game_macros.svh"

module note_fetcher #(
    parameter int note_period = `DEF_NOTE_PERIOD
) (
    input  logic clk_in,
    input  logic rst_in,
    note_stream_if.fetch ns,
    output logic [`ROM_ADDR_W-1:0] rom_addr,
    input  logic [`ROM_DATA_W-1:0] rom_data
);

    localparam int PERIOD_W = $clog2(note_period + 1);
    localparam int PRELOAD_LAST = 2 * `WINDOW_NOTES; // address cycle, then two per note

    game_pkg::note_window_u window;
    game_pkg::note_t fetched_note;
    logic [PERIOD_W-1:0] period_cnt;
    logic [3:0] preload_cnt;
    logic preloading;
    logic running; // a song has been started
    logic end_seen;
    logic do_shift;

    // everything after the end marker reads as a rest
    assign fetched_note = end_seen ? `REST_NOTE : rom_data[`NOTE_W-1:0];

    always_comb begin
        if (!running) begin
            do_shift = 1'b0;
        end else if (preloading) begin
            do_shift = (preload_cnt != 4'd0) && !preload_cnt[0]; // even counts carry rom data
        end else if (ns.learn) begin
            do_shift = ns.advance;
        end else begin
            do_shift = (period_cnt == PERIOD_W'(note_period - 1));
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            window <= '0;
            rom_addr <= '0;
            period_cnt <= '0;
            preload_cnt <= '0;
            preloading <= 1'b0;
            running <= 1'b0;
            end_seen <= 1'b0;
            ns.shift <= 1'b0;
        end else if (ns.start) begin
            window.flat <= '0;
            period_cnt <= '0;
            preload_cnt <= '0;
            preloading <= 1'b1;
            running <= 1'b1;
            end_seen <= 1'b0;
            ns.shift <= 1'b0;
        end else begin
            ns.shift <= do_shift;
            if (preloading) begin
                preload_cnt <= preload_cnt + 4'd1;
                if (preload_cnt == 4'd0) begin
                    // song choice is latched by now
                    rom_addr <= `ROM_ADDR_W'(ns.song_choice * `SONG_STRIDE);
                end
                if (preload_cnt == 4'(PRELOAD_LAST)) begin
                    preloading <= 1'b0;
                end
            end
            if (do_shift) begin
                window.notes <= {window.notes[`WINDOW_NOTES-2:0], fetched_note};
                rom_addr <= rom_addr + 1'b1;
                if (fetched_note == `END_NOTE) begin
                    end_seen <= 1'b1;
                end
            end
            // period counter only matters in play
            if (preloading || do_shift || ns.learn) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    assign ns.window = window;

endmodule

// File: logic/song_menu.sv
`timescale 1ns/100ps

module song_menu (
    input  logic clk_in,
    input  logic rst_in,
    input  logic btnu,
    input  logic btnd,
    input  logic custom_song_activated,
    output game_pkg::song_choice_t choice
);

    game_pkg::song_choice_t top_choice;
    logic btnu_prev;
    logic btnd_prev;
    logic up_edge;
    logic down_edge;

    assign top_choice = custom_song_activated ? 2'd3 : 2'd2; // custom slot on top
    assign up_edge = btnu && !btnu_prev;
    assign down_edge = btnd && !btnd_prev;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            btnu_prev <= 1'b0;
            btnd_prev <= 1'b0;
            choice <= '0;
        end else begin
            btnu_prev <= btnu;
            btnd_prev <= btnd;
            if (choice > top_choice) begin
                choice <= top_choice; // custom song went away
            end else if (up_edge && (choice < top_choice)) begin
                choice <= choice + 2'd1;
            end else if (down_edge && (choice != 2'd0)) begin
                choice <= choice - 2'd1;
            end
        end
    end

endmodule

// File: logic/session_regs.sv
`timescale 1ns/100ps

module session_regs (
    input  logic clk_in,
    input  logic rst_in,
    input  logic game_on,
    input  logic [1:0] game_type_in,
    input  game_pkg::song_choice_t menu_choice,
    note_stream_if.cfg ns
);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ns.learn <= 1'b0; // play
            ns.song_choice <= '0;
        end else begin
            // type is fixed once the game is on
            if (!game_on) begin
                ns.learn <= (game_type_in == game_pkg::TYPE_LEARN);
            end
            if (ns.start) begin
                ns.song_choice <= menu_choice; // cursor at the moment of the press
            end
        end
    end

endmodule

// File: logic/game_fsm.sv
`timescale 1ns/100ps
`include "game_macros.svh"

module game_fsm (
    input  logic clk_in,
    input  logic rst_in,
    input  logic game_on,
    input  logic btnc,
    input  logic custom_song_activated,
    note_stream_if.ctrl ns,
    output game_pkg::game_state_e state,
    output game_pkg::vga_mode_e vga_mode
);

    game_pkg::game_state_e next_state;
    logic song_end;

    // window still holds the previous song while start is high
    assign song_end = (ns.window.notes[`WINDOW_NOTES-1] == `END_NOTE) && !ns.start;

    always_comb begin
        next_state = state;
        if (!game_on) begin
            next_state = game_pkg::ST_IDLE; // switched off, back to start
        end else begin
            case (state)
                game_pkg::ST_IDLE: begin
                    if (!btnc) begin
                        next_state = game_pkg::ST_SONG_SELECT;
                    end
                end
                game_pkg::ST_SONG_SELECT: begin
                    if (btnc) begin
                        next_state = ns.learn ? game_pkg::ST_LEARN : game_pkg::ST_PLAY;
                    end
                end
                game_pkg::ST_PLAY, game_pkg::ST_LEARN: begin
                    if (song_end) begin
                        next_state = game_pkg::ST_FINISH;
                    end
                end
                default: next_state = game_pkg::ST_IDLE; // finish lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= game_pkg::ST_IDLE;
            ns.start <= 1'b0;
        end else begin
            state <= next_state;
            ns.start <= game_on && btnc && (state == game_pkg::ST_SONG_SELECT);
        end
    end

    // display mode
    always_comb begin
        case (state)
            game_pkg::ST_SONG_SELECT: begin
                vga_mode = custom_song_activated ? game_pkg::VGA_CUSTOM_SONG_MENU
                                                 : game_pkg::VGA_BASIC_SONG_MENU;
            end
            game_pkg::ST_PLAY: vga_mode = game_pkg::VGA_GAME;
            game_pkg::ST_LEARN: vga_mode = game_pkg::VGA_LEARN;
            default: vga_mode = game_pkg::VGA_MAIN_MENU;
        endcase
    end

endmodule

// File: logic/note_stream_if.sv
`timescale 1ns/100ps

interface note_stream_if;

    logic start; // one cycle, song begins
    game_pkg::song_choice_t song_choice;
    logic learn; // latched game type
    game_pkg::note_window_u window;
    logic shift; // window just changed
    logic advance; // learn mode step

    modport ctrl (output start, input window, input learn);

    modport cfg (input start, output song_choice, output learn);

    modport fetch (
        input start,
        input song_choice,
        input learn,
        input advance,
        output window,
        output shift
    );

    modport judge (input window, output advance);

endinterface

// File: logic/game_pkg.sv
`include "game_macros.svh"

package game_pkg;

    typedef enum logic [3:0] {
        ST_IDLE = 4'd0,
        ST_SONG_SELECT = 4'd2,
        ST_PLAY = 4'd3,
        ST_LEARN = 4'd4,
        ST_FINISH = 4'd5
    } game_state_e;

    typedef enum logic [1:0] {
        TYPE_LEARN = 2'd2,
        TYPE_PLAY = 2'd3
    } game_type_e;

    typedef logic [1:0] song_choice_t;

    typedef enum logic [2:0] {
        VGA_MAIN_MENU = 3'd0,
        VGA_BASIC_SONG_MENU = 3'd3,
        VGA_CUSTOM_SONG_MENU = 3'd4,
        VGA_LEARN = 3'd5,
        VGA_GAME = 3'd6
    } vga_mode_e;

    typedef logic [`NOTE_W-1:0] note_t;

    // element 4 is the head note, element 0 the newest one
    typedef union packed {
        logic [`WINDOW_NOTES*`NOTE_W-1:0] flat;
        note_t [`WINDOW_NOTES-1:0] notes;
    } note_window_u;

endpackage

// File: include/game_macros.svh
`ifndef GAME_MACROS_SVH
`define GAME_MACROS_SVH

// note and window geometry
`define NOTE_W 7
`define WINDOW_NOTES 5

// external song rom
`define ROM_DATA_W 8
`define ROM_ADDR_W 10
`define SONG_STRIDE 250 // rom words between song starts

`define SCORE_W 12

// special note codes
`define END_NOTE 7'd124
`define REST_NOTE 7'd127

// default periods in clock cycles
`define DEF_NOTE_PERIOD 25_000_000
`define DEF_NOTE_HOLD 25_000_000
`define DEF_SCORE_INTERVAL 10_000_000

`endif
